// ==== verilog/board_cfg_pkg.sv ====
// board widths, player count and joystick vector types
package board_cfg_pkg;

    // players wired to the board
    localparam int num_players = 4;

    // raw joystick width as delivered by the board
    localparam int joy_raw_w = 16;

    // joystick width seen by the game core
    localparam int joy_game_w = 10;

    // graphics layers that can be switched off from the keyboard
    localparam int gfx_layers = 4;

    // one raw board joystick, directions in the low nibble
    typedef logic [joy_raw_w-1:0] joy_raw_t;

    // directions plus game buttons, coin, start and pause bits
    typedef logic [joy_game_w-1:0] joy_game_t;

    // one bit per player, coin and start buttons
    typedef logic [num_players-1:0] player_vec_t;

    // layer enables, bit 0 is the first layer
    typedef logic [gfx_layers-1:0] gfx_vec_t;

endpackage

// ==== verilog/input_map_pkg.sv ====
// joystick bit positions, direction field type and 4-way filter state enum
package input_map_pkg;

    // direction bits inside a joystick word
    localparam int dir_right = 0;
    localparam int dir_left  = 1;
    localparam int dir_down  = 2;
    localparam int dir_up    = 3;

    // game buttons start right above the directions
    localparam int first_button_bit = 4;

    // the four direction bits of a joystick
    typedef logic [first_button_bit-1:0] dir_bits_t;

    // direction held by the 4-way filter
    // none means no direction pressed
    typedef enum logic [2:0] {
        none,
        up,
        down,
        left,
        right
    } dir_state_t;

endpackage

// ==== verilog/joy_4way_filter.sv ====
// 8-way to 4-way joystick direction filter
`timescale 1ns/1ps

module joy_4way_filter (
    input  logic                     clk_sys,
    input  logic                     rst,
    input  logic                     enable,
    input  input_map_pkg::dir_bits_t joy8,
    output input_map_pkg::dir_bits_t joy4
);
    import input_map_pkg::*;

    dir_state_t state_q;
    dir_state_t state_next;
    dir_bits_t  pass_q;

    // one-hot direction for the held state
    function automatic dir_bits_t state_to_bits(input dir_state_t st);
        dir_bits_t bits;
        bits = '0;
        case (st)
            up:      bits[dir_up]    = 1'b1;
            down:    bits[dir_down]  = 1'b1;
            left:    bits[dir_left]  = 1'b1;
            right:   bits[dir_right] = 1'b1;
            default: bits = '0;
        endcase
        return bits;
    endfunction

    // diagonals keep whatever was held before
    always_comb begin
        state_next = state_q;
        if (joy8 == '0) begin
            state_next = none;
        end else if ($onehot(joy8)) begin
            if (joy8[dir_up])
                state_next = up;
            else if (joy8[dir_down])
                state_next = down;
            else if (joy8[dir_left])
                state_next = left;
            else
                state_next = right;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst || !enable)
            state_q <= none;
        else
            state_q <= state_next;
    end

    // 8-way mode, plain register
    always_ff @(posedge clk_sys) begin
        pass_q <= joy8;
    end

    assign joy4 = enable ? state_to_bits(state_q) : pass_q;

endmodule

// ==== verilog/player_input_mapper.sv ====
// per-player joystick sync, 4-way filter, key merge, rotation and inversion
`timescale 1ns/1ps

module player_input_mapper #(
    parameter int buttons           = 2,
    parameter bit inputs_active_low = 1'b1
) (
    input  logic                     clk_sys,
    input  logic                     rst,
    input  board_cfg_pkg::joy_raw_t  joy_raw,
    input  board_cfg_pkg::joy_game_t key_joy,
    input  logic                     four_way,
    input  logic                     rotate_en,
    input  logic                     flip,
    output board_cfg_pkg::joy_raw_t  joy_sync,
    output board_cfg_pkg::joy_game_t game_joy
);
    import board_cfg_pkg::*;
    import input_map_pkg::*;

    dir_bits_t dir_filt;
    joy_game_t merged;

    // buttons must fit in the game joystick word
    if (first_button_bit + buttons > joy_game_w) begin : g_bad_buttons
        $error("too many buttons for the game joystick width");
    end

    // screen rotation of the direction field only
    function automatic joy_game_t rotate_dirs(
        input joy_game_t joy_in,
        input logic      rot,
        input logic      flip_en
    );
        joy_game_t joy_out;
        joy_out = joy_in;
        if (rot) begin
            if (flip_en) begin
                joy_out[dir_up]    = joy_in[dir_left];
                joy_out[dir_down]  = joy_in[dir_right];
                joy_out[dir_left]  = joy_in[dir_down];
                joy_out[dir_right] = joy_in[dir_up];
            end else begin
                joy_out[dir_up]    = joy_in[dir_right];
                joy_out[dir_down]  = joy_in[dir_left];
                joy_out[dir_left]  = joy_in[dir_up];
                joy_out[dir_right] = joy_in[dir_down];
            end
        end
        return joy_out;
    endfunction

    // directions enter the filter straight from the board
    joy_4way_filter u_filter (
        .clk_sys (clk_sys),
        .rst     (rst),
        .enable  (four_way),
        .joy8    (joy_raw[first_button_bit-1:0]),
        .joy4    (dir_filt)
    );

    // buttons take one stage here, directions already had the filter stage
    always_ff @(posedge clk_sys) begin
        joy_sync <= {joy_raw[joy_raw_w-1:first_button_bit], dir_filt};
    end

    assign merged = joy_sync[joy_game_w-1:0] | key_joy;

    always_ff @(posedge clk_sys) begin
        game_joy <= rotate_dirs(merged, rotate_en, flip) ^ {joy_game_w{inputs_active_low}};
    end

endmodule

// ==== verilog/board_controls.sv ====
// coin and start gathering, pause toggle, soft reset pulse, gfx enables and service
`timescale 1ns/1ps

module board_controls #(
    parameter int buttons           = 2,
    parameter bit inputs_active_low = 1'b1
) (
    input  logic                       clk_sys,
    input  logic                       rst,
    input  board_cfg_pkg::joy_raw_t    joy_sync1,
    input  board_cfg_pkg::joy_raw_t    joy_sync2,
    input  board_cfg_pkg::joy_raw_t    joy_sync3,
    input  board_cfg_pkg::joy_raw_t    joy_sync4,
    input  board_cfg_pkg::player_vec_t key_coin,
    input  board_cfg_pkg::player_vec_t key_start,
    input  logic                       key_reset,
    input  logic                       key_pause,
    input  logic                       key_service,
    input  board_cfg_pkg::gfx_vec_t    key_gfx,
    input  logic                       osd_pause,
    input  logic                       downloading,
    output board_cfg_pkg::player_vec_t game_coin,
    output board_cfg_pkg::player_vec_t game_start,
    output logic                       game_service,
    output logic                       game_pause,
    output logic                       soft_rst,
    output board_cfg_pkg::gfx_vec_t    gfx_en
);
    import board_cfg_pkg::*;
    import input_map_pkg::*;

    // bits above the game buttons in a raw joystick
    localparam int start_bit = first_button_bit + buttons;
    localparam int coin_bit  = start_bit + 1;
    localparam int pause_bit = start_bit + 2;

    if (pause_bit >= joy_raw_w) begin : g_bad_buttons
        $error("pause bit falls outside the raw joystick");
    end

    joy_raw_t    joy_sync_all [num_players];
    player_vec_t coin_joy;
    player_vec_t start_joy;
    logic        joy_pause;
    logic        pause_rise;
    gfx_vec_t    gfx_rise;

    // previous input levels for edge detection
    logic        last_key_pause;
    logic        last_joy_pause;
    logic        last_osd_pause;
    logic        last_key_reset;
    gfx_vec_t    last_key_gfx;

    assign joy_sync_all = '{joy_sync1, joy_sync2, joy_sync3, joy_sync4};

    always_comb begin
        for (int p = 0; p < num_players; p++) begin
            coin_joy[p]  = joy_sync_all[p][coin_bit];
            start_joy[p] = joy_sync_all[p][start_bit];
        end
    end

    // only players 1 and 2 can pause
    assign joy_pause = joy_sync1[pause_bit] | joy_sync2[pause_bit];

    always_ff @(posedge clk_sys) begin
        game_coin  <= (coin_joy | key_coin) ^ {num_players{inputs_active_low}};
        game_start <= (start_joy | key_start) ^ {num_players{inputs_active_low}};
    end

    always_ff @(posedge clk_sys) begin
        last_key_pause <= key_pause;
        last_joy_pause <= joy_pause;
        last_osd_pause <= osd_pause;
        last_key_reset <= key_reset;
        last_key_gfx   <= key_gfx;
    end

    assign pause_rise = (key_pause & ~last_key_pause) | (joy_pause & ~last_joy_pause);
    assign gfx_rise   = key_gfx & ~last_key_gfx;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause   <= 1'b0;
            soft_rst     <= 1'b0;
            gfx_en       <= '1;
            game_service <= inputs_active_low;
        end else begin
            soft_rst     <= key_reset & ~last_key_reset;
            gfx_en       <= gfx_en ^ gfx_rise;
            game_service <= key_service ^ inputs_active_low;
            // a ROM download always unpauses
            if (downloading)
                game_pause <= 1'b0;
            else if (osd_pause != last_osd_pause)
                game_pause <= osd_pause;
            else if (pause_rise)
                game_pause <= ~game_pause;
        end
    end

endmodule

// ==== verilog/input_board_top.sv ====
// input board top with four player mappers and the board controls
`timescale 1ns/1ps

module input_board_top #(
    parameter int buttons           = 2,
    parameter bit inputs_active_low = 1'b1
) (
    input  logic                       clk_sys,
    input  logic                       rst,
    input  board_cfg_pkg::joy_raw_t    joy_raw1,
    input  board_cfg_pkg::joy_raw_t    joy_raw2,
    input  board_cfg_pkg::joy_raw_t    joy_raw3,
    input  board_cfg_pkg::joy_raw_t    joy_raw4,
    input  board_cfg_pkg::joy_game_t   key_joy1,
    input  board_cfg_pkg::joy_game_t   key_joy2,
    input  board_cfg_pkg::joy_game_t   key_joy3,
    input  board_cfg_pkg::player_vec_t key_coin,
    input  board_cfg_pkg::player_vec_t key_start,
    input  logic                       key_reset,
    input  logic                       key_pause,
    input  logic                       key_service,
    input  board_cfg_pkg::gfx_vec_t    key_gfx,
    input  logic                       four_way,
    input  logic                       rotate_en,
    input  logic                       flip,
    input  logic                       osd_pause,
    input  logic                       downloading,
    output board_cfg_pkg::joy_game_t   game_joy1,
    output board_cfg_pkg::joy_game_t   game_joy2,
    output board_cfg_pkg::joy_game_t   game_joy3,
    output board_cfg_pkg::joy_game_t   game_joy4,
    output board_cfg_pkg::player_vec_t game_coin,
    output board_cfg_pkg::player_vec_t game_start,
    output logic                       game_service,
    output logic                       game_pause,
    output logic                       soft_rst,
    output board_cfg_pkg::gfx_vec_t    gfx_en
);
    import board_cfg_pkg::*;

    joy_raw_t joy_sync1, joy_sync2, joy_sync3, joy_sync4;

    // the keyboard has no keys for player 4
    wire joy_game_t key_joy4 = '0;

    player_input_mapper #(.buttons(buttons), .inputs_active_low(inputs_active_low)) u_p1 (
        .clk_sys (clk_sys), .rst (rst), .joy_raw (joy_raw1), .key_joy (key_joy1),
        .four_way (four_way), .rotate_en (rotate_en), .flip (flip),
        .joy_sync (joy_sync1), .game_joy (game_joy1)
    );

    player_input_mapper #(.buttons(buttons), .inputs_active_low(inputs_active_low)) u_p2 (
        .clk_sys (clk_sys), .rst (rst), .joy_raw (joy_raw2), .key_joy (key_joy2),
        .four_way (four_way), .rotate_en (rotate_en), .flip (flip),
        .joy_sync (joy_sync2), .game_joy (game_joy2)
    );

    player_input_mapper #(.buttons(buttons), .inputs_active_low(inputs_active_low)) u_p3 (
        .clk_sys (clk_sys), .rst (rst), .joy_raw (joy_raw3), .key_joy (key_joy3),
        .four_way (four_way), .rotate_en (rotate_en), .flip (flip),
        .joy_sync (joy_sync3), .game_joy (game_joy3)
    );

    player_input_mapper #(.buttons(buttons), .inputs_active_low(inputs_active_low)) u_p4 (
        .clk_sys (clk_sys), .rst (rst), .joy_raw (joy_raw4), .key_joy (key_joy4),
        .four_way (four_way), .rotate_en (rotate_en), .flip (flip),
        .joy_sync (joy_sync4), .game_joy (game_joy4)
    );

    board_controls #(.buttons(buttons), .inputs_active_low(inputs_active_low)) u_controls (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .joy_sync1    (joy_sync1),
        .joy_sync2    (joy_sync2),
        .joy_sync3    (joy_sync3),
        .joy_sync4    (joy_sync4),
        .key_coin     (key_coin),
        .key_start    (key_start),
        .key_reset    (key_reset),
        .key_pause    (key_pause),
        .key_service  (key_service),
        .key_gfx      (key_gfx),
        .osd_pause    (osd_pause),
        .downloading  (downloading),
        .game_coin    (game_coin),
        .game_start   (game_start),
        .game_service (game_service),
        .game_pause   (game_pause),
        .soft_rst     (soft_rst),
        .gfx_en       (gfx_en)
    );

endmodule

// ==== tb/input_board_checker.sv ====
// concurrent assertions on soft reset, gfx enable and pause timing, bound to the input board top
`timescale 1ns/1ps

module input_board_checker (
    input logic                    clk_sys,
    input logic                    rst,
    input logic                    key_reset,
    input logic                    soft_rst,
    input board_cfg_pkg::gfx_vec_t key_gfx,
    input board_cfg_pkg::gfx_vec_t gfx_en,
    input logic                    downloading,
    input logic                    game_pause
);
    // failed assertions, read back by the testbench at the end
    int assert_fails = 0;

    // every key_reset rise gives a pulse one cycle later
    a_soft_rst_after_rise: assert property (@(posedge clk_sys) disable iff (rst)
        $rose(key_reset) |=> soft_rst)
        else begin
            $error("soft_rst missing one cycle after a key_reset rise");
            assert_fails++;
        end

    // no pulse without a key_reset rise just before
    a_soft_rst_cause: assert property (@(posedge clk_sys) disable iff (rst)
        soft_rst |-> ($past(key_reset) && !$past(key_reset, 2)))
        else begin
            $error("soft_rst pulse without a preceding key_reset rise");
            assert_fails++;
        end

    a_soft_rst_width: assert property (@(posedge clk_sys) disable iff (rst)
        soft_rst |=> !soft_rst)
        else begin
            $error("soft_rst lasted more than one cycle");
            assert_fails++;
        end

    // changed gfx bits are exactly the key bits that rose a cycle earlier
    a_gfx_toggle: assert property (@(posedge clk_sys) disable iff (rst)
        (gfx_en ^ $past(gfx_en)) == ($past(key_gfx) & ~$past(key_gfx, 2)))
        else begin
            $error("gfx_en changed without a matching key_gfx rise");
            assert_fails++;
        end

    a_download_unpause: assert property (@(posedge clk_sys) disable iff (rst)
        downloading |=> !game_pause)
        else begin
            $error("game_pause still set one cycle after downloading");
            assert_fails++;
        end

endmodule

bind input_board_top input_board_checker u_checker (
    .clk_sys     (clk_sys),
    .rst         (rst),
    .key_reset   (key_reset),
    .soft_rst    (soft_rst),
    .key_gfx     (key_gfx),
    .gfx_en      (gfx_en),
    .downloading (downloading),
    .game_pause  (game_pause)
);

// ==== tb/input_board_tb.sv ====
// testbench for the input board with stimulus, reference model, checks and error counts
`timescale 1ns/1ps

module input_board_tb;
    import board_cfg_pkg::*;
    import input_map_pkg::*;

    // raw joystick bits above two game buttons
    localparam int start_bit   = 6;
    localparam int coin_bit    = 7;
    localparam int pause_bit   = 8;
    localparam int hold_cycles = 4;
    localparam int wait_limit  = 16;

    logic        clk_sys = 1'b0;
    logic        rst;
    joy_raw_t    joy_raw1, joy_raw2, joy_raw3, joy_raw4;
    joy_game_t   key_joy1, key_joy2, key_joy3;
    player_vec_t key_coin, key_start;
    logic        key_reset, key_pause, key_service;
    gfx_vec_t    key_gfx;
    logic        four_way, rotate_en, flip, osd_pause, downloading;
    joy_game_t   game_joy1, game_joy2, game_joy3, game_joy4;
    player_vec_t game_coin, game_start;
    logic        game_service, game_pause, soft_rst;
    gfx_vec_t    gfx_en;

    int          seed = 55770;
    int          errors = 0;
    gfx_vec_t    gfx_model;
    player_vec_t exp_coin;
    player_vec_t exp_start;

    input_board_top DUT (.*);

    initial begin
        forever #10 clk_sys = ~clk_sys;
    end

    // all stimulus changes land on a falling edge
    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk_sys);
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // merged word as the game sees it, rotated and inverted
    function automatic joy_game_t expected_joy(input joy_game_t merged, input logic rot,
                                               input logic flp);
        logic [3:0] dirs;
        dirs = merged[3:0];
        if (rot && flp)
            dirs = {merged[dir_left], merged[dir_right], merged[dir_down], merged[dir_up]};
        else if (rot)
            dirs = {merged[dir_right], merged[dir_left], merged[dir_up], merged[dir_down]};
        return ~{merged[9:4], dirs};
    endfunction

    task automatic check_joys(input string name, input joy_game_t m1, m2, m3, m4);
        check_value({name, " p1"}, expected_joy(m1, rotate_en, flip), game_joy1);
        check_value({name, " p2"}, expected_joy(m2, rotate_en, flip), game_joy2);
        check_value({name, " p3"}, expected_joy(m3, rotate_en, flip), game_joy3);
        check_value({name, " p4"}, expected_joy(m4, rotate_en, flip), game_joy4);
    endtask

    // same direction bits on every player, buttons released
    task automatic filter_step(input string name, input dir_bits_t dirs_in,
                               input dir_bits_t dirs_exp);
        joy_raw1 = {12'h000, dirs_in};
        joy_raw2 = {12'h000, dirs_in};
        joy_raw3 = {12'h000, dirs_in};
        joy_raw4 = {12'h000, dirs_in};
        idle_cycles(hold_cycles);
        check_joys(name, {6'b0, dirs_exp}, {6'b0, dirs_exp}, {6'b0, dirs_exp}, {6'b0, dirs_exp});
    endtask

    task automatic press_reset_key();
        int waited;
        int width;
        waited = 0;
        width = 0;
        key_reset = 1'b1;
        while (!soft_rst && waited < wait_limit) begin
            @(negedge clk_sys);
            waited++;
        end
        if (!soft_rst) begin
            $display("soft_rst pulse did not appear after key_reset was pressed");
            errors++;
        end else begin
            while (soft_rst && width < wait_limit) begin
                @(negedge clk_sys);
                width++;
            end
            check_value("soft reset pulse width", 1, width);
        end
        idle_cycles(hold_cycles);
        check_value("soft reset while key held", 0, soft_rst);
        key_reset = 1'b0;
        idle_cycles(hold_cycles);
        check_value("soft reset after release", 0, soft_rst);
    endtask

    initial begin
        rst = 1'b1;
        {joy_raw1, joy_raw2, joy_raw3, joy_raw4} = '0;
        {key_joy1, key_joy2, key_joy3} = '0;
        key_coin = '0;
        key_start = '0;
        {key_reset, key_pause, key_service} = 3'b001;
        key_gfx = '0;
        {four_way, rotate_en, flip, osd_pause, downloading} = 5'b00000;
        idle_cycles(10);

        // service key held in reset so the reset value differs from the live one
        check_value("reset gfx_en", 4'hf, gfx_en);
        check_value("reset game_pause", 0, game_pause);
        check_value("reset soft_rst", 0, soft_rst);
        check_value("reset game_service", 1, game_service);
        rst = 1'b0;
        key_service = 1'b0;
        idle_cycles(2);

        key_service = 1'b1;
        idle_cycles(hold_cycles);
        check_value("service pressed", 0, game_service);
        key_service = 1'b0;
        idle_cycles(hold_cycles);
        check_value("service released", 1, game_service);

        // rotation modes in order, rotate_en low first
        for (int mode = 0; mode < 4; mode++) begin
            rotate_en = mode[1];
            flip = mode[0];
            for (int n = 0; n < 4; n++) begin
                joy_raw1 = $random(seed);
                joy_raw2 = $random(seed);
                joy_raw3 = $random(seed);
                joy_raw4 = $random(seed);
                key_joy1 = $random(seed);
                key_joy2 = $random(seed);
                key_joy3 = $random(seed);
                idle_cycles(hold_cycles);
                check_joys("joystick mapping", joy_raw1[9:0] | key_joy1,
                           joy_raw2[9:0] | key_joy2, joy_raw3[9:0] | key_joy3, joy_raw4[9:0]);
            end
        end

        rotate_en = 1'b0;
        flip = 1'b0;
        {key_joy1, key_joy2, key_joy3} = '0;
        four_way = 1'b1;
        filter_step("4-way idle", 4'b0000, 4'b0000);
        filter_step("4-way up", 4'b1000, 4'b1000);
        filter_step("4-way up plus left", 4'b1010, 4'b1000);
        filter_step("4-way release", 4'b0000, 4'b0000);
        filter_step("4-way right", 4'b0001, 4'b0001);
        filter_step("4-way right plus down", 4'b0101, 4'b0001);
        filter_step("4-way release again", 4'b0000, 4'b0000);
        four_way = 1'b0;

        // coin and start bits only, so pause stays untouched
        for (int n = 0; n < 8; n++) begin
            joy_raw1 = $random(seed) & 16'h00c0;
            joy_raw2 = $random(seed) & 16'h00c0;
            joy_raw3 = $random(seed) & 16'h00c0;
            joy_raw4 = $random(seed) & 16'h00c0;
            key_coin = $random(seed);
            key_start = $random(seed);
            idle_cycles(hold_cycles);
            exp_coin = ~({joy_raw4[coin_bit], joy_raw3[coin_bit], joy_raw2[coin_bit],
                          joy_raw1[coin_bit]} | key_coin);
            exp_start = ~({joy_raw4[start_bit], joy_raw3[start_bit], joy_raw2[start_bit],
                           joy_raw1[start_bit]} | key_start);
            check_value("coin", exp_coin, game_coin);
            check_value("start", exp_start, game_start);
        end
        key_coin = '0;
        key_start = '0;

        filter_step("buttons cleared", 4'b0000, 4'b0000);
        downloading = 1'b1;
        idle_cycles(hold_cycles);
        check_value("pause cleared by download", 0, game_pause);
        downloading = 1'b0;
        idle_cycles(hold_cycles);
        check_value("pause stays clear", 0, game_pause);
        key_pause = 1'b1;
        idle_cycles(hold_cycles);
        check_value("pause key press", 1, game_pause);
        key_pause = 1'b0;
        idle_cycles(hold_cycles);
        check_value("pause key release", 1, game_pause);
        joy_raw2[pause_bit] = 1'b1;
        idle_cycles(hold_cycles);
        check_value("joystick pause press", 0, game_pause);
        joy_raw2 = '0;
        idle_cycles(hold_cycles);
        check_value("joystick pause release", 0, game_pause);
        osd_pause = 1'b1;
        idle_cycles(hold_cycles);
        check_value("menu pause", 1, game_pause);
        downloading = 1'b1;
        idle_cycles(hold_cycles);
        check_value("download over menu pause", 0, game_pause);
        downloading = 1'b0;
        osd_pause = 1'b0;
        idle_cycles(hold_cycles);
        check_value("menu pause released", 0, game_pause);

        press_reset_key();

        gfx_model = '1;
        for (int n = 0; n < 5; n++) begin
            key_gfx = (n < 4) ? gfx_vec_t'(1 << n) : 4'b1010;
            idle_cycles(hold_cycles);
            gfx_model = gfx_model ^ key_gfx;
            check_value("gfx toggle on press", gfx_model, gfx_en);
            key_gfx = '0;
            idle_cycles(hold_cycles);
            check_value("gfx unchanged on release", gfx_model, gfx_en);
        end

        $display("check errors: %0d, assertion errors: %0d", errors, DUT.u_checker.assert_fails);
        if (errors == 0 && DUT.u_checker.assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
verilog/board_cfg_pkg.sv
verilog/input_map_pkg.sv
verilog/joy_4way_filter.sv
verilog/player_input_mapper.sv
verilog/board_controls.sv
verilog/input_board_top.sv
tb/input_board_checker.sv
tb/input_board_tb.sv
